//--- common/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Data words and instruction addresses share one width
`define DATA_W 32

// Architectural register file
`define REG_ADDR_W 5
`define NUM_REGS 32

// Every in-flight result is named by a tag from the free-tag FIFO
`define TAG_W 6
`define NUM_TAGS 64

`endif

//--- common/dispatch_pkg.sv
`include "dispatch_config.svh"

package dispatch_pkg;

   typedef logic [`DATA_W-1:0] data_t;
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`TAG_W-1:0] tag_t;

   // Primary opcodes handled by this dispatch stage
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      J     = 6'h02,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      LW    = 6'h23,
      SW    = 6'h2b
   } opcode_t;

   // R-type functions that leave the integer queue
   typedef enum logic [5:0] {
      MULT  = 6'h18,
      MULTU = 6'h19,
      DIV   = 6'h1a,
      DIVU  = 6'h1b
   } funct_t;

   typedef enum logic [1:0] {
      Q_INT  = 2'd0,
      Q_LS   = 2'd1,
      Q_MULT = 2'd2,
      Q_DIV  = 2'd3
   } queue_sel_t;

   typedef enum logic {
      LS_LW = 1'b0,
      LS_SW = 1'b1
   } ls_op_t;

endpackage

//--- dispatch/inst_decoder.sv
module inst_decoder
   import dispatch_pkg::*;
(
   input  data_t      inst,
   input  data_t      pc_plus4,
   output reg_addr_t  rs_addr,
   output reg_addr_t  rt_addr,
   output reg_addr_t  dest_addr,
   output queue_sel_t queue_sel,
   output logic       needs_queue,
   output logic       needs_tag,
   output logic       is_branch,
   output logic       is_jump,
   output logic       is_load,
   output logic       is_store,
   output logic [5:0] int_opcode,
   output ls_op_t     ls_opcode,
   output data_t      imm,
   output data_t      jump_addr,
   output data_t      branch_addr
);

   opcode_t     opcode;
   funct_t      funct;
   reg_addr_t   rd_addr;
   logic [15:0] imm16;
   logic [25:0] jump_field;

   // R, I and J formats overlap, so every field is split unconditionally
   assign opcode     = opcode_t'(inst[31:26]);
   assign rs_addr    = inst[25:21];
   assign rt_addr    = inst[20:16];
   assign rd_addr    = inst[15:11];
   assign funct      = funct_t'(inst[5:0]);
   assign imm16      = inst[15:0];
   assign jump_field = inst[25:0];

   always_comb begin
      queue_sel   = Q_INT;
      needs_queue = 1'b0;
      needs_tag   = 1'b0;
      is_branch   = 1'b0;
      is_jump     = 1'b0;
      is_load     = 1'b0;
      is_store    = 1'b0;
      int_opcode  = 6'h00;
      ls_opcode   = LS_LW;
      case (opcode)
         RTYPE: begin
            needs_queue = 1'b1;
            needs_tag   = 1'b1;
            case (funct)
               MULT, MULTU: queue_sel = Q_MULT;
               DIV, DIVU:   queue_sel = Q_DIV;
               default:     int_opcode = inst[5:0];
            endcase
         end
         BEQ, BNE: begin
            // Branches only compare, they never write a register
            needs_queue = 1'b1;
            is_branch   = 1'b1;
            int_opcode  = inst[31:26];
         end
         LW: begin
            queue_sel   = Q_LS;
            needs_queue = 1'b1;
            needs_tag   = 1'b1;
            is_load     = 1'b1;
            ls_opcode   = LS_LW;
         end
         SW: begin
            queue_sel   = Q_LS;
            needs_queue = 1'b1;
            is_store    = 1'b1;
            ls_opcode   = LS_SW;
         end
         J: is_jump = 1'b1;
         default: ;
      endcase
   end

   // A load writes rt, everything else that takes a tag writes rd
   assign dest_addr = is_load ? rt_addr : rd_addr;

   assign imm         = {{16{imm16[15]}}, imm16};
   assign branch_addr = pc_plus4 + {imm[29:0], 2'b00};
   assign jump_addr   = {pc_plus4[31:28], jump_field, 2'b00};

endmodule

//--- dispatch/dispatch_ctrl.sv
module dispatch_ctrl
   import dispatch_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ifq_empty,
   input  logic       tag_empty,
   input  logic       needs_queue,
   input  logic       needs_tag,
   input  logic       is_branch,
   input  logic       is_jump,
   input  logic       is_load,
   input  logic       is_store,
   input  queue_sel_t queue_sel,
   input  tag_t       rs_tag,
   input  tag_t       rt_tag,
   input  logic       rs_busy,
   input  logic       rt_busy,
   input  data_t      rs_rf_data,
   input  data_t      rt_rf_data,
   input  data_t      jump_addr,
   input  data_t      branch_addr,
   input  tag_t       head_tag,
   input  logic       cdb_valid,
   input  tag_t       cdb_tag,
   input  data_t      cdb_data,
   input  logic       cdb_branch,
   input  logic       cdb_branch_taken,
   input  logic       int_ready,
   input  logic       ls_ready,
   input  logic       mult_ready,
   input  logic       div_ready,
   output logic       int_en,
   output logic       ls_en,
   output logic       mult_en,
   output logic       div_en,
   output logic       ifq_ren,
   output logic       ifq_branch_valid,
   output data_t      ifq_branch_addr,
   output logic       tag_pop,
   output logic       rst_write,
   output tag_t       rd_tag,
   output tag_t       rs_tag_out,
   output tag_t       rt_tag_out,
   output logic       rs_valid,
   output logic       rt_valid,
   output data_t      rs_data,
   output data_t      rt_data
);

   typedef enum logic {S_DISPATCH, S_BRANCH_STALL} state_t;

   state_t state;
   data_t  branch_target_r;
   logic   target_ready;
   logic   may_issue;
   logic   dispatch;
   logic   rs_fwd;
   logic   rt_fwd;

   always_comb begin
      case (queue_sel)
         Q_INT:   target_ready = int_ready;
         Q_LS:    target_ready = ls_ready;
         Q_MULT:  target_ready = mult_ready;
         default: target_ready = div_ready;
      endcase
   end

   // While a branch is unresolved only a not-taken result lets the next instruction go
   assign may_issue = (state == S_DISPATCH) || (cdb_branch && !cdb_branch_taken);
   assign dispatch  = needs_queue && target_ready && !ifq_empty && may_issue
                      && (!needs_tag || !tag_empty);

   assign int_en    = dispatch && (queue_sel == Q_INT);
   assign ls_en     = dispatch && (queue_sel == Q_LS);
   assign mult_en   = dispatch && (queue_sel == Q_MULT);
   assign div_en    = dispatch && (queue_sel == Q_DIV);
   assign ifq_ren   = dispatch;
   assign tag_pop   = dispatch && needs_tag;
   assign rst_write = dispatch && needs_tag;

   // Jumps redirect at once, taken branches redirect from the stall state
   assign ifq_branch_valid = (state == S_DISPATCH) ? (is_jump && !ifq_empty)
                                                   : (cdb_branch && cdb_branch_taken);
   assign ifq_branch_addr  = (state == S_DISPATCH) ? jump_addr : branch_target_r;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_DISPATCH;
      end else if (dispatch && is_branch) begin
         state <= S_BRANCH_STALL;
      end else if (state == S_BRANCH_STALL && cdb_branch) begin
         state <= S_DISPATCH;
      end
   end

   always_ff @(posedge clk) begin
      if (dispatch && is_branch) begin
         branch_target_r <= branch_addr;
      end
   end

   // A result on the CDB this cycle has not reached the register file yet
   assign rs_fwd = cdb_valid && rs_busy && (cdb_tag == rs_tag);
   assign rt_fwd = cdb_valid && rt_busy && (cdb_tag == rt_tag);

   assign rd_tag     = head_tag;
   assign rs_tag_out = rs_tag;
   assign rt_tag_out = is_load ? head_tag : rt_tag;
   assign rs_valid   = !rs_busy || rs_fwd;
   assign rt_valid   = is_store || !rt_busy || rt_fwd;
   assign rs_data    = rs_fwd ? cdb_data : rs_rf_data;
   assign rt_data    = rt_fwd ? cdb_data : rt_rf_data;

   // A branch outcome with no branch outstanding would be lost
   a_outcome_in_stall: assert property (@(posedge clk) disable iff (reset)
      cdb_branch |-> state == S_BRANCH_STALL);

   a_taken_has_outcome: assert property (@(posedge clk) disable iff (reset)
      cdb_branch_taken |-> cdb_branch);

endmodule

//--- hw/reg_file.sv
`include "dispatch_config.svh"

module reg_file
   import dispatch_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  data_t                wdata,
   input  logic [`NUM_REGS-1:0] wen_onehot,
   input  reg_addr_t            rs_addr,
   input  reg_addr_t            rt_addr,
   input  reg_addr_t            debug_addr,
   output data_t                rs_data,
   output data_t                rt_data,
   output data_t                debug_data
);

   data_t regs [`NUM_REGS];

   // The status table decides which register a CDB result belongs to
   always_ff @(posedge clk) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         if (reset) begin
            regs[i] <= '0;
         end else if (wen_onehot[i]) begin
            regs[i] <= wdata;
         end
      end
   end

   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

endmodule

//--- hw/reg_status_table.sv
`include "dispatch_config.svh"

module reg_status_table
   import dispatch_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  reg_addr_t            rs_addr,
   input  reg_addr_t            rt_addr,
   output tag_t                 rs_tag,
   output tag_t                 rt_tag,
   output logic                 rs_busy,
   output logic                 rt_busy,
   input  logic                 write,
   input  reg_addr_t            write_addr,
   input  tag_t                 write_tag,
   input  logic                 cdb_valid,
   input  tag_t                 cdb_tag,
   output logic [`NUM_REGS-1:0] wen_onehot
);

   logic [`NUM_REGS-1:0] busy_r;
   tag_t                 tag_r [`NUM_REGS];

   assign rs_tag  = tag_r[rs_addr];
   assign rt_tag  = tag_r[rt_addr];
   assign rs_busy = busy_r[rs_addr];
   assign rt_busy = busy_r[rt_addr];

   // Only the latest producer of a register may write it back
   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         wen_onehot[i] = cdb_valid && busy_r[i] && (tag_r[i] == cdb_tag);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         if (reset) begin
            busy_r[i] <= 1'b0;
         end else if (write && write_addr == reg_addr_t'(i)) begin
            // A new dispatch wins over a broadcast of the older tag
            busy_r[i] <= 1'b1;
         end else if (wen_onehot[i]) begin
            busy_r[i] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (write) begin
         tag_r[write_addr] <= write_tag;
      end
   end

   // Tags in flight are unique, so a broadcast names at most one register
   a_wen_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(wen_onehot));

endmodule

//--- hw/tag_fifo.sv
`include "dispatch_config.svh"

module tag_fifo
   import dispatch_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic pop,
   output tag_t head_tag,
   output logic empty,
   input  logic push,
   input  tag_t push_tag
);

   localparam int PTR_W = $clog2(`NUM_TAGS);
   localparam int CNT_W = PTR_W + 1;

   tag_t             mem [`NUM_TAGS];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`NUM_TAGS - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign head_tag = mem[rd_ptr];
   assign empty    = (count == '0);
   assign full     = (count == CNT_W'(`NUM_TAGS));

   // Every tag starts out free, in ascending order
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_TAGS; i++) begin
            mem[i] <= tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= CNT_W'(`NUM_TAGS);
      end else begin
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push) begin
            mem[wr_ptr] <= push_tag;
            wr_ptr      <= next_ptr(wr_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // A returned tag must have been handed out earlier
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      push |-> !full);

endmodule

//--- dispatch/dispatch_unit.sv
`include "dispatch_config.svh"

module dispatch_unit
   import dispatch_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  data_t      inst,
   input  data_t      pc_plus4,
   input  logic       ifq_empty,
   output logic       ifq_ren,
   output logic       ifq_branch_valid,
   output data_t      ifq_branch_addr,
   input  logic       cdb_valid,
   input  tag_t       cdb_tag,
   input  data_t      cdb_data,
   input  logic       cdb_branch,
   input  logic       cdb_branch_taken,
   output data_t      imm,
   output tag_t       rd_tag,
   output tag_t       rs_tag,
   output tag_t       rt_tag,
   output data_t      rs_data,
   output data_t      rt_data,
   output logic       rs_valid,
   output logic       rt_valid,
   input  logic       int_ready,
   output logic       int_en,
   output logic [5:0] int_opcode,
   input  logic       ls_ready,
   output logic       ls_en,
   output ls_op_t     ls_opcode,
   input  logic       mult_ready,
   output logic       mult_en,
   input  logic       div_ready,
   output logic       div_en,
   input  reg_addr_t  debug_addr,
   output data_t      debug_data
);

   reg_addr_t          rs_addr;
   reg_addr_t          rt_addr;
   reg_addr_t          dest_addr;
   queue_sel_t         queue_sel;
   logic               needs_queue;
   logic               needs_tag;
   logic               is_branch;
   logic               is_jump;
   logic               is_load;
   logic               is_store;
   data_t              jump_addr;
   data_t              branch_addr;
   data_t              rs_rf_data;
   data_t              rt_rf_data;
   tag_t               rst_rs_tag;
   tag_t               rst_rt_tag;
   logic               rs_busy;
   logic               rt_busy;
   logic               rst_write;
   logic [`NUM_REGS-1:0] wen_onehot;
   tag_t               head_tag;
   logic               tag_empty;
   logic               tag_pop;

   inst_decoder decoder_i (
      .inst        (inst),
      .pc_plus4    (pc_plus4),
      .rs_addr     (rs_addr),
      .rt_addr     (rt_addr),
      .dest_addr   (dest_addr),
      .queue_sel   (queue_sel),
      .needs_queue (needs_queue),
      .needs_tag   (needs_tag),
      .is_branch   (is_branch),
      .is_jump     (is_jump),
      .is_load     (is_load),
      .is_store    (is_store),
      .int_opcode  (int_opcode),
      .ls_opcode   (ls_opcode),
      .imm         (imm),
      .jump_addr   (jump_addr),
      .branch_addr (branch_addr)
   );

   dispatch_ctrl ctrl_i (
      .clk              (clk),
      .reset            (reset),
      .ifq_empty        (ifq_empty),
      .tag_empty        (tag_empty),
      .needs_queue      (needs_queue),
      .needs_tag        (needs_tag),
      .is_branch        (is_branch),
      .is_jump          (is_jump),
      .is_load          (is_load),
      .is_store         (is_store),
      .queue_sel        (queue_sel),
      .rs_tag           (rst_rs_tag),
      .rt_tag           (rst_rt_tag),
      .rs_busy          (rs_busy),
      .rt_busy          (rt_busy),
      .rs_rf_data       (rs_rf_data),
      .rt_rf_data       (rt_rf_data),
      .jump_addr        (jump_addr),
      .branch_addr      (branch_addr),
      .head_tag         (head_tag),
      .cdb_valid        (cdb_valid),
      .cdb_tag          (cdb_tag),
      .cdb_data         (cdb_data),
      .cdb_branch       (cdb_branch),
      .cdb_branch_taken (cdb_branch_taken),
      .int_ready        (int_ready),
      .ls_ready         (ls_ready),
      .mult_ready       (mult_ready),
      .div_ready        (div_ready),
      .int_en           (int_en),
      .ls_en            (ls_en),
      .mult_en          (mult_en),
      .div_en           (div_en),
      .ifq_ren          (ifq_ren),
      .ifq_branch_valid (ifq_branch_valid),
      .ifq_branch_addr  (ifq_branch_addr),
      .tag_pop          (tag_pop),
      .rst_write        (rst_write),
      .rd_tag           (rd_tag),
      .rs_tag_out       (rs_tag),
      .rt_tag_out       (rt_tag),
      .rs_valid         (rs_valid),
      .rt_valid         (rt_valid),
      .rs_data          (rs_data),
      .rt_data          (rt_data)
   );

   reg_file reg_file_i (
      .clk        (clk),
      .reset      (reset),
      .wdata      (cdb_data),
      .wen_onehot (wen_onehot),
      .rs_addr    (rs_addr),
      .rt_addr    (rt_addr),
      .debug_addr (debug_addr),
      .rs_data    (rs_rf_data),
      .rt_data    (rt_rf_data),
      .debug_data (debug_data)
   );

   reg_status_table rst_i (
      .clk        (clk),
      .reset      (reset),
      .rs_addr    (rs_addr),
      .rt_addr    (rt_addr),
      .rs_tag     (rst_rs_tag),
      .rt_tag     (rst_rt_tag),
      .rs_busy    (rs_busy),
      .rt_busy    (rt_busy),
      .write      (rst_write),
      .write_addr (dest_addr),
      .write_tag  (head_tag),
      .cdb_valid  (cdb_valid),
      .cdb_tag    (cdb_tag),
      .wen_onehot (wen_onehot)
   );

   tag_fifo tag_fifo_i (
      .clk      (clk),
      .reset    (reset),
      .pop      (tag_pop),
      .head_tag (head_tag),
      .empty    (tag_empty),
      .push     (cdb_valid),
      .push_tag (cdb_tag)
   );

endmodule

//--- tb/dispatch_unit_tb.sv
`include "dispatch_config.svh"

module dispatch_unit_tb
   import dispatch_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   // The whole test runs for a few hundred cycles
   localparam int MAX_CYCLES = 3000;

   logic       clk;
   logic       reset;
   data_t      inst, pc_plus4, ifq_branch_addr;
   logic       ifq_empty, ifq_ren, ifq_branch_valid;
   logic       cdb_valid, cdb_branch, cdb_branch_taken;
   tag_t       cdb_tag, rd_tag, rs_tag, rt_tag;
   data_t      cdb_data, imm, rs_data, rt_data, debug_data;
   logic       rs_valid, rt_valid;
   logic       int_ready, ls_ready, mult_ready, div_ready;
   logic       int_en, ls_en, mult_en, div_en;
   logic [5:0] int_opcode;
   ls_op_t     ls_opcode;
   reg_addr_t  debug_addr;
   integer     seed;

   // Reference model of the free-tag FIFO, the status table and the registers
   tag_t  free_tags[$];
   tag_t  in_flight[$];
   logic  busy [`NUM_REGS];
   tag_t  pend [`NUM_REGS];
   data_t model_val [`NUM_REGS];
   logic  stalled;
   data_t target;

   dispatch_unit dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic expect_true(input logic ok, input string what);
      assert (ok) else abort_run($sformatf("[FAIL] %0t: %s", $time, what));
   endtask

   a_ren_matches_en: assert property (@(posedge clk) disable iff (reset)
      ifq_ren == (int_en || ls_en || mult_en || div_en))
      else abort_run($sformatf("[FAIL] %0t: ifq_ren differs from the queue enables", $time));

   a_en_needs_ready: assert property (@(posedge clk) disable iff (reset)
      (!int_en || int_ready) && (!ls_en || ls_ready) && (!mult_en || mult_ready)
      && (!div_en || div_ready))
      else abort_run($sformatf("[FAIL] %0t: queue enable without ready", $time));

   a_no_ren_on_redirect: assert property (@(posedge clk) disable iff (reset)
      ifq_branch_valid |-> !ifq_ren)
      else abort_run($sformatf("[FAIL] %0t: instruction consumed during redirect", $time));

   function automatic data_t rnd();
      return $random(seed);
   endfunction

   function automatic reg_addr_t rreg();
      logic [31:0] v;
      v = $random(seed);
      return v[4:0];
   endfunction

   function automatic data_t r_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [5:0] fn);
      return {6'h00, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic data_t i_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] im);
      return {op, rs, rt, im};
   endfunction

   // Puts a result on the CDB for one cycle and retires its tag from the model
   task automatic broadcast(input tag_t t, input data_t d);
      cdb_valid = 1'b1;
      cdb_tag   = t;
      cdb_data  = d;
      for (int i = 0; i < in_flight.size(); i++) begin
         if (in_flight[i] == t) begin
            in_flight.delete(i);
            break;
         end
      end
   endtask

   // Checks one cycle against the model, then advances the model over the edge
   task automatic run_cycle();
      logic [5:0] op;
      logic [5:0] fn;
      reg_addr_t  rs_a, rt_a, dst;
      queue_sel_t q;
      logic       nq, nt, ready, may, go, rs_ok, rt_ok, bv;
      data_t      sext, exp_addr;
      tag_t       new_tag;
      op   = inst[31:26];
      fn   = inst[5:0];
      rs_a = inst[25:21];
      rt_a = inst[20:16];
      dst  = inst[15:11];
      sext = {{16{inst[15]}}, inst[15:0]};
      q    = Q_INT;
      nq   = 1'b0;
      nt   = 1'b0;
      if (op == RTYPE) begin
         nq = 1'b1;
         nt = 1'b1;
         if (fn == MULT || fn == MULTU) q = Q_MULT;
         else if (fn == DIV || fn == DIVU) q = Q_DIV;
      end else if (op == BEQ || op == BNE) begin
         nq = 1'b1;
      end else if (op == LW || op == SW) begin
         nq  = 1'b1;
         nt  = (op == LW);
         q   = Q_LS;
         dst = rt_a;
      end
      case (q)
         Q_INT:   ready = int_ready;
         Q_LS:    ready = ls_ready;
         Q_MULT:  ready = mult_ready;
         default: ready = div_ready;
      endcase
      may = !stalled || (cdb_branch && !cdb_branch_taken);
      go  = nq && ready && !ifq_empty && may && (!nt || free_tags.size() > 0);
      #10;
      expect_true(ifq_ren == go, $sformatf("ifq_ren %0b, expected %0b", ifq_ren, go));
      expect_true({int_en, ls_en, mult_en, div_en} == {go && q == Q_INT, go && q == Q_LS,
                  go && q == Q_MULT, go && q == Q_DIV}, "wrong queue enable");
      if (go && nt) begin
         expect_true(rd_tag == free_tags[0],
                     $sformatf("rd_tag %0d, expected %0d", rd_tag, free_tags[0]));
      end
      if (go && q == Q_INT) begin
         expect_true(int_opcode == ((op == RTYPE) ? fn : op), "wrong int_opcode");
      end
      if (go && q == Q_LS) begin
         expect_true((ls_opcode == LS_SW) == (op == SW), "wrong ls_opcode");
         expect_true(op == SW || rt_tag == free_tags[0], "load rt_tag is not its rd_tag");
      end
      if (go) begin
         expect_true(imm == sext, $sformatf("imm %h, expected %h", imm, sext));
         rs_ok = !busy[rs_a] || (cdb_valid && cdb_tag == pend[rs_a]);
         expect_true(rs_valid == rs_ok, "wrong rs_valid");
         if (rs_ok) expect_true(rs_data == (busy[rs_a] ? cdb_data : model_val[rs_a]),
                                $sformatf("rs_data %h is wrong", rs_data));
         else expect_true(rs_tag == pend[rs_a], "rs_tag is not the pending tag");
         if (op == SW) begin
            expect_true(rt_valid, "store without rt_valid");
         end else if (op != LW) begin
            rt_ok = !busy[rt_a] || (cdb_valid && cdb_tag == pend[rt_a]);
            expect_true(rt_valid == rt_ok, "wrong rt_valid");
            if (rt_ok) expect_true(rt_data == (busy[rt_a] ? cdb_data : model_val[rt_a]),
                                   $sformatf("rt_data %h is wrong", rt_data));
            else expect_true(rt_tag == pend[rt_a], "rt_tag is not the pending tag");
         end
      end
      if (!stalled) begin
         bv       = (op == J) && !ifq_empty;
         exp_addr = {pc_plus4[31:28], inst[25:0], 2'b00};
      end else begin
         bv       = cdb_branch && cdb_branch_taken;
         exp_addr = target;
      end
      expect_true(ifq_branch_valid == bv, "wrong ifq_branch_valid");
      if (bv) expect_true(ifq_branch_addr == exp_addr,
                          $sformatf("redirect to %h, expected %h", ifq_branch_addr, exp_addr));
      expect_true(debug_data == model_val[debug_addr],
                  $sformatf("debug_data %h, expected %h", debug_data, model_val[debug_addr]));
      @(posedge clk);
      if (cdb_valid) begin
         for (int n = 0; n < `NUM_REGS; n++) begin
            if (busy[n] && pend[n] == cdb_tag) begin
               model_val[n] = cdb_data;
               busy[n]      = 1'b0;
            end
         end
         free_tags.push_back(cdb_tag);
      end
      if (go && nt) begin
         new_tag   = free_tags.pop_front();
         busy[dst] = 1'b1;
         pend[dst] = new_tag;
         in_flight.push_back(new_tag);
      end
      if (go && (op == BEQ || op == BNE)) begin
         stalled = 1'b1;
         target  = pc_plus4 + {sext[29:0], 2'b00};
      end else if (stalled && cdb_branch) begin
         stalled = 1'b0;
      end
      @(negedge clk);
      cdb_valid        = 1'b0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
   endtask

   task automatic random_traffic(input int cycles);
      logic [31:0] r;
      int          idx;
      for (int k = 0; k < cycles; k++) begin
         r = rnd();
         case (r[2:0])
            3'd4:    inst = r_word(rreg(), rreg(), rreg(), r[31] ? MULTU : DIV);
            3'd5:    inst = i_word(LW, rreg(), rreg(), r[30:15]);
            3'd6:    inst = i_word(SW, rreg(), rreg(), r[30:15]);
            default: inst = r_word(rreg(), rreg(), rreg(), 6'h20);
         endcase
         int_ready  = (r[9:8] != 2'b00);
         ls_ready   = (r[11:10] != 2'b00);
         mult_ready = r[12];
         div_ready  = r[13];
         ifq_empty  = (r[16:14] == 3'b000);
         if (in_flight.size() > 0 && r[17]) begin
            idx = int'(r[27:20]) % in_flight.size();
            broadcast(in_flight[idx], rnd());
         end
         debug_addr = rreg();
         pc_plus4   = rnd();
         run_cycle();
      end
   endtask

   initial begin
      seed = 32'h45fc;
      reset = 1'b1;
      inst = '0;
      pc_plus4 = 32'h0040_0004;
      ifq_empty = 1'b1;
      {int_ready, ls_ready, mult_ready, div_ready} = 4'b1111;
      {cdb_valid, cdb_branch, cdb_branch_taken} = 3'b000;
      cdb_tag = '0;
      cdb_data = '0;
      debug_addr = '0;
      stalled = 1'b0;
      target = '0;
      for (int n = 0; n < `NUM_REGS; n++) begin
         busy[n] = 1'b0;
         pend[n] = '0;
         model_val[n] = '0;
      end
      for (int n = 0; n < `NUM_TAGS; n++) free_tags.push_back(tag_t'(n));
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      run_cycle();

      // Tags come out in order and each class reaches its own queue
      ifq_empty = 1'b0;
      for (int k = 0; k < 6; k++) begin
         inst = r_word(rreg(), rreg(), rreg(), 6'(32 + k));
         run_cycle();
      end
      inst = r_word(rreg(), rreg(), rreg(), MULT);
      run_cycle();
      inst = r_word(rreg(), rreg(), rreg(), DIVU);
      run_cycle();
      inst = i_word(LW, rreg(), rreg(), 16'h8004);
      run_cycle();
      inst = i_word(SW, rreg(), rreg(), 16'h0010);
      run_cycle();

      // Back-pressure from the queues and from the fetch queue
      int_ready = 1'b0;
      inst = r_word(5'd1, 5'd2, 5'd3, 6'h20);
      run_cycle();
      run_cycle();
      int_ready = 1'b1;
      ifq_empty = 1'b1;
      run_cycle();
      ifq_empty = 1'b0;
      run_cycle();
      ls_ready = 1'b0;
      inst = i_word(LW, 5'd4, 5'd6, 16'h0020);
      run_cycle();
      ls_ready = 1'b1;
      run_cycle();

      // r7 gets a producer, then is read while pending and while on the CDB
      inst = r_word(5'd1, 5'd2, 5'd7, 6'h20);
      run_cycle();
      inst = r_word(5'd7, 5'd7, 5'd8, 6'h21);
      run_cycle();
      debug_addr = 5'd7;
      broadcast(pend[7], 32'hcafe_0007);
      inst = r_word(5'd7, 5'd3, 5'd9, 6'h22);
      run_cycle();
      ifq_empty = 1'b1;
      run_cycle();

      // Enough traffic to reissue returned tags after the first 64
      random_traffic(250);
      {int_ready, ls_ready, mult_ready, div_ready} = 4'b1111;
      ifq_empty = 1'b1;
      while (in_flight.size() > 0) begin
         debug_addr = rreg();
         broadcast(in_flight[0], rnd());
         run_cycle();
      end

      ifq_empty = 1'b0;
      pc_plus4 = rnd();
      inst = rnd();
      inst[31:26] = J;
      run_cycle();

      // Not-taken branch releases the next instruction in the resolving cycle
      pc_plus4 = 32'h0040_1000;
      inst = i_word(BEQ, rreg(), rreg(), 16'hfff0);
      run_cycle();
      pc_plus4 = 32'h0040_1004;
      inst = r_word(rreg(), rreg(), rreg(), 6'h20);
      run_cycle();
      run_cycle();
      cdb_branch = 1'b1;
      run_cycle();

      // Taken branch redirects to its own target and drops the next instruction
      pc_plus4 = 32'h0040_2000;
      inst = i_word(BNE, rreg(), rreg(), 16'h0010);
      run_cycle();
      pc_plus4 = 32'h0040_2004;
      inst = r_word(rreg(), rreg(), rreg(), 6'h24);
      run_cycle();
      cdb_branch = 1'b1;
      cdb_branch_taken = 1'b1;
      run_cycle();
      ifq_empty = 1'b1;
      run_cycle();

      $display("Everything OK");
      $finish;
   end

   initial begin
      #(MAX_CYCLES * CLK_PERIOD);
      abort_run($sformatf("Watchdog timeout, the test did not end within %0d cycles",
                          MAX_CYCLES));
   end

endmodule

//--- list.f
+incdir+common
common/dispatch_pkg.sv
dispatch/inst_decoder.sv
dispatch/dispatch_ctrl.sv
hw/reg_file.sv
hw/reg_status_table.sv
hw/tag_fifo.sv
dispatch/dispatch_unit.sv
tb/dispatch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module dispatch_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vdispatch_unit_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1
